/* rvIsaPkg.sv */
// RV32I ISA package with field types, opcodes, funct3 codes and instruction IDs
`default_nettype none

package rvIsaPkg;

    localparam int instIdDepth = 8;

    typedef logic [31:0] instWord;
    typedef logic [4:0] regAddr;
    typedef logic [6:0] opcodeT;
    typedef logic [2:0] funct3T;
    typedef logic [31:0] immWord;
    typedef logic [instIdDepth-1:0] instIdT;

    // major opcodes
    localparam opcodeT opIComp = 7'b0010011;
    localparam opcodeT opR     = 7'b0110011;
    localparam opcodeT opLui   = 7'b0110111;
    localparam opcodeT opAuipc = 7'b0010111;
    localparam opcodeT opB     = 7'b1100011;
    localparam opcodeT opJal   = 7'b1101111;
    localparam opcodeT opJalr  = 7'b1100111;
    localparam opcodeT opLoad  = 7'b0000011;
    localparam opcodeT opStore = 7'b0100011;

    // funct3, shared by R and I-compute
    localparam funct3T f3AddSub = 3'b000;
    localparam funct3T f3Sll    = 3'b001;
    localparam funct3T f3Slt    = 3'b010;
    localparam funct3T f3Sltu   = 3'b011;
    localparam funct3T f3Xor    = 3'b100;
    localparam funct3T f3SrlSra = 3'b101;
    localparam funct3T f3Or     = 3'b110;
    localparam funct3T f3And    = 3'b111;

    localparam funct3T f3Beq  = 3'b000;
    localparam funct3T f3Bne  = 3'b001;
    localparam funct3T f3Blt  = 3'b100;
    localparam funct3T f3Bge  = 3'b101;
    localparam funct3T f3Bltu = 3'b110;
    localparam funct3T f3Bgeu = 3'b111;

    localparam funct3T f3Lb  = 3'b000;
    localparam funct3T f3Lh  = 3'b001;
    localparam funct3T f3Lw  = 3'b010;
    localparam funct3T f3Lbu = 3'b100;
    localparam funct3T f3Lhu = 3'b101;

    localparam funct3T f3Sb = 3'b000;
    localparam funct3T f3Sh = 3'b001;
    localparam funct3T f3Sw = 3'b010;

    localparam funct3T f3Jalr = 3'b000;

    // instruction IDs, zero reserved for illegal
    localparam instIdT idIllegal = 8'd0;
    localparam instIdT idAddi  = 8'd1;
    localparam instIdT idSlti  = 8'd2;
    localparam instIdT idSltiu = 8'd3;
    localparam instIdT idXori  = 8'd4;
    localparam instIdT idOri   = 8'd5;
    localparam instIdT idAndi  = 8'd6;
    localparam instIdT idSlli  = 8'd7;
    localparam instIdT idSrli  = 8'd8;
    localparam instIdT idSrai  = 8'd9;
    localparam instIdT idAdd   = 8'd10;
    localparam instIdT idSub   = 8'd11;
    localparam instIdT idSll   = 8'd12;
    localparam instIdT idSlt   = 8'd13;
    localparam instIdT idSltu  = 8'd14;
    localparam instIdT idXor   = 8'd15;
    localparam instIdT idSrl   = 8'd16;
    localparam instIdT idSra   = 8'd17;
    localparam instIdT idOr    = 8'd18;
    localparam instIdT idAnd   = 8'd19;
    localparam instIdT idLui   = 8'd20;
    localparam instIdT idAuipc = 8'd21;
    localparam instIdT idJal   = 8'd22;
    localparam instIdT idJalr  = 8'd23;
    localparam instIdT idBeq   = 8'd24;
    localparam instIdT idBne   = 8'd25;
    localparam instIdT idBlt   = 8'd26;
    localparam instIdT idBge   = 8'd27;
    localparam instIdT idBltu  = 8'd28;
    localparam instIdT idBgeu  = 8'd29;
    localparam instIdT idLb    = 8'd30;
    localparam instIdT idLh    = 8'd31;
    localparam instIdT idLw    = 8'd32;
    localparam instIdT idLbu   = 8'd33;
    localparam instIdT idLhu   = 8'd34;
    localparam instIdT idSb    = 8'd35;
    localparam instIdT idSh    = 8'd36;
    localparam instIdT idSw    = 8'd37;

endpackage

`default_nettype wire

/* frontPkg.sv */
// front-end package with pc and memory word types, reset vector and fetch states
`default_nettype none

package frontPkg;

    typedef logic [31:0] pcWord;
    typedef logic [31:0] memWord;

    localparam pcWord resetVector = 32'h0000_0000;
    localparam pcWord pcStep = 32'd4; // sequential advance

    typedef enum logic [2:0] {
        sIdle,
        sReq,
        sWait,
        sIssue,
        sHold
    } fetchState;

endpackage

`default_nettype wire

/* instructionDecode.sv */
// RV32I decoder turning an instruction word into fields, flags, immediate and ID
`timescale 1ns/1ps
`default_nettype none

module instructionDecode (
    input  rvIsaPkg::instWord inst,
    output rvIsaPkg::opcodeT  opcode,
    output rvIsaPkg::regAddr  rs1,
    output rvIsaPkg::regAddr  rs2,
    output rvIsaPkg::regAddr  rd,
    output logic              rs1Vld,
    output logic              rs2Vld,
    output logic              rdVld,
    output rvIsaPkg::immWord  imm,
    output rvIsaPkg::instIdT  instId,
    output logic              jmpVld
);
    import rvIsaPkg::*;

    funct3T funct3;
    immWord immI;
    immWord immS;
    immWord immB;
    immWord immU;
    immWord immJ;

    // fixed field positions
    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {inst[31:12], 12'd0};
    assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign jmpVld = (opcode == opJal); // fed straight back to the pc

    always_comb begin
        instId = idIllegal;
        imm    = '0;
        rs1Vld = 1'b0;
        rs2Vld = 1'b0;
        rdVld  = 1'b0;
        case (opcode)
            opIComp: begin
                {rs1Vld, rs2Vld, rdVld} = 3'b101;
                imm = immI;
                case (funct3)
                    f3AddSub: instId = idAddi;
                    f3Slt:    instId = idSlti;
                    f3Sltu:   instId = idSltiu;
                    f3Xor:    instId = idXori;
                    f3Or:     instId = idOri;
                    f3And:    instId = idAndi;
                    f3Sll:    instId = idSlli;
                    f3SrlSra: instId = inst[30] ? idSrai : idSrli;
                    default:  instId = idIllegal;
                endcase
            end
            opR: begin
                {rs1Vld, rs2Vld, rdVld} = 3'b111;
                case (funct3)
                    f3AddSub: instId = inst[30] ? idSub : idAdd;
                    f3Sll:    instId = idSll;
                    f3Slt:    instId = idSlt;
                    f3Sltu:   instId = idSltu;
                    f3Xor:    instId = idXor;
                    f3SrlSra: instId = inst[30] ? idSra : idSrl;
                    f3Or:     instId = idOr;
                    f3And:    instId = idAnd;
                    default:  instId = idIllegal;
                endcase
            end
            opLui: begin
                {rs1Vld, rs2Vld, rdVld} = 3'b001;
                imm    = immU;
                instId = idLui;
            end
            opAuipc: begin
                {rs1Vld, rs2Vld, rdVld} = 3'b001;
                imm    = immU;
                instId = idAuipc;
            end
            opJal: begin
                {rs1Vld, rs2Vld, rdVld} = 3'b001;
                imm    = immJ;
                instId = idJal;
            end
            opJalr: begin
                {rs1Vld, rs2Vld, rdVld} = 3'b101;
                imm = immI;
                if (funct3 == f3Jalr)
                    instId = idJalr;
            end
            opB: begin
                {rs1Vld, rs2Vld, rdVld} = 3'b110;
                imm = immB;
                case (funct3)
                    f3Beq:   instId = idBeq;
                    f3Bne:   instId = idBne;
                    f3Blt:   instId = idBlt;
                    f3Bge:   instId = idBge;
                    f3Bltu:  instId = idBltu;
                    f3Bgeu:  instId = idBgeu;
                    default: instId = idIllegal;
                endcase
            end
            opLoad: begin
                {rs1Vld, rs2Vld, rdVld} = 3'b101;
                imm = immI;
                case (funct3)
                    f3Lb:    instId = idLb;
                    f3Lh:    instId = idLh;
                    f3Lw:    instId = idLw;
                    f3Lbu:   instId = idLbu;
                    f3Lhu:   instId = idLhu;
                    default: instId = idIllegal;
                endcase
            end
            opStore: begin
                {rs1Vld, rs2Vld, rdVld} = 3'b110;
                imm = immS;
                case (funct3)
                    f3Sb:    instId = idSb;
                    f3Sh:    instId = idSh;
                    f3Sw:    instId = idSw;
                    default: instId = idIllegal;
                endcase
            end
            default: instId = idIllegal;
        endcase

        // bad funct3 under a good opcode
        if (instId == idIllegal) begin
            {rs1Vld, rs2Vld, rdVld} = 3'b000;
            imm = '0;
        end
    end

endmodule

`default_nettype wire

/* fetchControl.sv */
// fetch FSM sequencing memory request, ack wait, issue and back-pressure hold
`timescale 1ns/1ps
`default_nettype none

module fetchControl (
    input  logic clk,
    input  logic arstN,
    input  logic run,
    input  logic memAck,
    input  logic stall,
    output logic memReq,
    output logic instLoad,
    output logic issue
);
    import frontPkg::*;

    fetchState state;
    fetchState stateNext;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            state <= sIdle;
        else
            state <= stateNext;
    end

    always_comb begin
        stateNext = state;
        case (state)
            sIdle:  if (run) stateNext = sReq;
            sReq:   stateNext = sWait;
            sWait:  if (memAck) stateNext = sIssue;
            sIssue: begin
                if (stall)
                    stateNext = sHold; // output still owned downstream
                else
                    stateNext = run ? sReq : sIdle;
            end
            sHold:  if (!stall) stateNext = sIssue;
            default: stateNext = sIdle;
        endcase
    end

    assign memReq   = (state == sReq);
    assign instLoad = (state == sWait) && memAck;
    assign issue    = (state == sIssue) && !stall;

    // memory answers only the request in flight
    assert property (@(posedge clk) disable iff (!arstN) memAck |-> state == sWait)
        else $error("memAck outside the wait state");

endmodule

`default_nettype wire

/* programCounter.sv */
// program counter stepping by 4 or jumping by the JAL offset on issue
`timescale 1ns/1ps
`default_nettype none

module programCounter (
    input  logic             clk,
    input  logic             arstN,
    input  logic             issue,
    input  logic             jmpVld,
    input  rvIsaPkg::immWord jmpOffset,
    output frontPkg::pcWord  pc
);
    import frontPkg::*;

    pcWord pcNext;

    assign pcNext = jmpVld ? pc + jmpOffset : pc + pcStep;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            pc <= resetVector;
        else if (issue)
            pc <= pcNext;
    end

    // word alignment survives as long as jump offsets are aligned
    assert property (@(posedge clk) disable iff (!arstN)
        issue && (!jmpVld || jmpOffset[1:0] == 2'b00) |=> pc[1:0] == 2'b00)
        else $error("pc misaligned: %h", pc);

endmodule

`default_nettype wire

/* decodeLatch.sv */
// output register holding one decoded instruction and its pc for execute
`timescale 1ns/1ps
`default_nettype none

module decodeLatch (
    input  logic             clk,
    input  logic             arstN,
    input  logic             issue,
    input  logic             stall,
    input  rvIsaPkg::opcodeT opcode,
    input  rvIsaPkg::regAddr rs1,
    input  rvIsaPkg::regAddr rs2,
    input  rvIsaPkg::regAddr rd,
    input  logic             rs1Vld,
    input  logic             rs2Vld,
    input  logic             rdVld,
    input  rvIsaPkg::immWord imm,
    input  rvIsaPkg::instIdT instId,
    input  frontPkg::pcWord  pc,
    output logic             outValid,
    output frontPkg::pcWord  outPc,
    output rvIsaPkg::opcodeT outOpcode,
    output rvIsaPkg::regAddr outRs1,
    output rvIsaPkg::regAddr outRs2,
    output rvIsaPkg::regAddr outRd,
    output logic             outRs1Vld,
    output logic             outRs2Vld,
    output logic             outRdVld,
    output rvIsaPkg::immWord outImm,
    output rvIsaPkg::instIdT outInstId
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            outValid <= 1'b0;
        else if (issue)
            outValid <= 1'b1;
        else if (!stall)
            outValid <= 1'b0; // consumed
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            outPc     <= pc;
            outOpcode <= opcode;
            outRs1    <= rs1;
            outRs2    <= rs2;
            outRd     <= rd;
            outRs1Vld <= rs1Vld;
            outRs2Vld <= rs2Vld;
            outRdVld  <= rdVld;
            outImm    <= imm;
            outInstId <= instId;
        end
    end

    // relies on the fetch FSM never issuing into a stalled output
    assert property (@(posedge clk) disable iff (!arstN)
        outValid && stall |=> outValid
            && $stable({outPc, outOpcode, outRs1, outRs2, outRd,
                        outRs1Vld, outRs2Vld, outRdVld, outImm, outInstId}))
        else $error("output changed under stall");

endmodule

`default_nettype wire

/* frontEnd.sv */
// RV32I front end with fetch control, pc, decoder and output register
`timescale 1ns/1ps
`default_nettype none

module frontEnd (
    input  logic             clk,
    input  logic             arstN,
    input  logic             run,
    output logic             memReq,
    output frontPkg::pcWord  memAddr,
    input  logic             memAck,
    input  frontPkg::memWord memData,
    input  logic             stall,
    output logic             outValid,
    output frontPkg::pcWord  outPc,
    output rvIsaPkg::opcodeT outOpcode,
    output rvIsaPkg::regAddr outRs1,
    output rvIsaPkg::regAddr outRs2,
    output rvIsaPkg::regAddr outRd,
    output logic             outRs1Vld,
    output logic             outRs2Vld,
    output logic             outRdVld,
    output rvIsaPkg::immWord outImm,
    output rvIsaPkg::instIdT outInstId
);
    import rvIsaPkg::*;
    import frontPkg::*;

    logic    instLoad;
    logic    issue;
    pcWord   pc;
    instWord instReg;

    opcodeT decOpcode;
    regAddr decRs1;
    regAddr decRs2;
    regAddr decRd;
    logic   decRs1Vld;
    logic   decRs2Vld;
    logic   decRdVld;
    immWord decImm;
    instIdT decInstId;
    logic   decJmpVld;

    assign memAddr = pc;

    // decoder input, captured with the ack
    always_ff @(posedge clk) begin
        if (instLoad)
            instReg <= memData;
    end

    fetchControl uFetchControl (
        .clk      (clk),
        .arstN    (arstN),
        .run      (run),
        .memAck   (memAck),
        .stall    (stall),
        .memReq   (memReq),
        .instLoad (instLoad),
        .issue    (issue)
    );

    programCounter uProgramCounter (
        .clk       (clk),
        .arstN     (arstN),
        .issue     (issue),
        .jmpVld    (decJmpVld),
        .jmpOffset (decImm),
        .pc        (pc)
    );

    instructionDecode uInstructionDecode (
        .inst   (instReg),
        .opcode (decOpcode),
        .rs1    (decRs1),
        .rs2    (decRs2),
        .rd     (decRd),
        .rs1Vld (decRs1Vld),
        .rs2Vld (decRs2Vld),
        .rdVld  (decRdVld),
        .imm    (decImm),
        .instId (decInstId),
        .jmpVld (decJmpVld)
    );

    decodeLatch uDecodeLatch (
        .clk       (clk),
        .arstN     (arstN),
        .issue     (issue),
        .stall     (stall),
        .opcode    (decOpcode),
        .rs1       (decRs1),
        .rs2       (decRs2),
        .rd        (decRd),
        .rs1Vld    (decRs1Vld),
        .rs2Vld    (decRs2Vld),
        .rdVld     (decRdVld),
        .imm       (decImm),
        .instId    (decInstId),
        .pc        (pc),
        .outValid  (outValid),
        .outPc     (outPc),
        .outOpcode (outOpcode),
        .outRs1    (outRs1),
        .outRs2    (outRs2),
        .outRd     (outRd),
        .outRs1Vld (outRs1Vld),
        .outRs2Vld (outRs2Vld),
        .outRdVld  (outRdVld),
        .outImm    (outImm),
        .outInstId (outInstId)
    );

endmodule

`default_nettype wire

/* tbFrontEnd.sv */
// testbench for the RV32I front end with memory model, program table and stall checks
`timescale 1ns/1ps
`default_nettype none

module tbFrontEnd;
    import rvIsaPkg::*;
    import frontPkg::*;

    localparam int numRows = 43;
    localparam int resetCycles = 8;
    localparam int idleCycles = 10;
    localparam int timeoutNs = (numRows * 10 + resetCycles + idleCycles) * 20;

    logic clk;
    logic arstN;
    logic run;
    logic memReq;
    pcWord memAddr;
    logic memAck;
    memWord memData;
    logic stall;
    logic outValid;
    pcWord outPc;
    opcodeT outOpcode;
    regAddr outRs1;
    regAddr outRs2;
    regAddr outRd;
    logic outRs1Vld;
    logic outRs2Vld;
    logic outRdVld;
    immWord outImm;
    instIdT outInstId;

    // program table
    string rowName [numRows];
    instWord rowWord [numRows];
    pcWord rowPc [numRows];
    instIdT rowId [numRows];
    regAddr rowRs1 [numRows];
    regAddr rowRs2 [numRows];
    regAddr rowRd [numRows];
    logic [2:0] rowVld [numRows]; // rs1, rs2, rd
    immWord rowImm [numRows];
    int rowCount = 0;

    memWord mem [64];
    bit isProgram [64];

    logic [31:0] lcgState = 32'h2a57_e8a2;
    int errCount = 0;
    int rowIdx = 0;
    int cycle = 0;
    bit holding = 0;
    logic [96:0] held;
    bit ackPending = 0;
    int ackWait = 0;
    pcWord reqAddr;
    bit sawReq = 0;

    frontEnd dut (
        .clk       (clk),
        .arstN     (arstN),
        .run       (run),
        .memReq    (memReq),
        .memAddr   (memAddr),
        .memAck    (memAck),
        .memData   (memData),
        .stall     (stall),
        .outValid  (outValid),
        .outPc     (outPc),
        .outOpcode (outOpcode),
        .outRs1    (outRs1),
        .outRs2    (outRs2),
        .outRd     (outRd),
        .outRs1Vld (outRs1Vld),
        .outRs2Vld (outRs2Vld),
        .outRdVld  (outRdVld),
        .outImm    (outImm),
        .outInstId (outInstId)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [96:0] packOutputs();
        return {outPc, outOpcode, outRs1, outRs2, outRd,
                outRs1Vld, outRs2Vld, outRdVld, outImm, outInstId};
    endfunction

    task automatic putRow(input string name, input instWord word, input pcWord pc,
                          input instIdT id, input regAddr rs1, input regAddr rs2,
                          input regAddr rd, input logic [2:0] vld, input immWord imm);
        rowName[rowCount] = name;
        rowWord[rowCount] = word;
        rowPc[rowCount] = pc;
        rowId[rowCount] = id;
        rowRs1[rowCount] = rs1;
        rowRs2[rowCount] = rs2;
        rowRd[rowCount] = rd;
        rowVld[rowCount] = vld;
        rowImm[rowCount] = imm;
        rowCount++;
    endtask

    // JAL rows skip over filler words at 0x28, 0x78 and 0x7c
    task automatic loadProgram();
        putRow("addi", 32'h00510093, 32'h00, idAddi, 5'd2, 5'd5, 5'd1, 3'b101, 32'h00000005);
        putRow("slti", 32'hfff12093, 32'h04, idSlti, 5'd2, 5'd31, 5'd1, 3'b101, 32'hffffffff);
        putRow("sltiu", 32'h00113093, 32'h08, idSltiu, 5'd2, 5'd1, 5'd1, 3'b101, 32'h00000001);
        putRow("xori", 32'h7ff14093, 32'h0c, idXori, 5'd2, 5'd31, 5'd1, 3'b101, 32'h000007ff);
        putRow("ori", 32'h80016093, 32'h10, idOri, 5'd2, 5'd0, 5'd1, 3'b101, 32'hfffff800);
        putRow("andi", 32'h0f017093, 32'h14, idAndi, 5'd2, 5'd16, 5'd1, 3'b101, 32'h000000f0);
        putRow("slli", 32'h00311093, 32'h18, idSlli, 5'd2, 5'd3, 5'd1, 3'b101, 32'h00000003);
        putRow("srli", 32'h00415093, 32'h1c, idSrli, 5'd2, 5'd4, 5'd1, 3'b101, 32'h00000004);
        putRow("srai", 32'h40415093, 32'h20, idSrai, 5'd2, 5'd4, 5'd1, 3'b101, 32'h00000404);
        putRow("jal+8", 32'h008000ef, 32'h24, idJal, 5'd0, 5'd8, 5'd1, 3'b001, 32'h00000008);
        putRow("add", 32'h003100b3, 32'h2c, idAdd, 5'd2, 5'd3, 5'd1, 3'b111, 32'h0);
        putRow("sub", 32'h403100b3, 32'h30, idSub, 5'd2, 5'd3, 5'd1, 3'b111, 32'h0);
        putRow("sll", 32'h003110b3, 32'h34, idSll, 5'd2, 5'd3, 5'd1, 3'b111, 32'h0);
        putRow("slt", 32'h003120b3, 32'h38, idSlt, 5'd2, 5'd3, 5'd1, 3'b111, 32'h0);
        putRow("sltu", 32'h003130b3, 32'h3c, idSltu, 5'd2, 5'd3, 5'd1, 3'b111, 32'h0);
        putRow("xor", 32'h003140b3, 32'h40, idXor, 5'd2, 5'd3, 5'd1, 3'b111, 32'h0);
        putRow("srl", 32'h003150b3, 32'h44, idSrl, 5'd2, 5'd3, 5'd1, 3'b111, 32'h0);
        putRow("sra", 32'h403150b3, 32'h48, idSra, 5'd2, 5'd3, 5'd1, 3'b111, 32'h0);
        putRow("or", 32'h003160b3, 32'h4c, idOr, 5'd2, 5'd3, 5'd1, 3'b111, 32'h0);
        putRow("and", 32'h003170b3, 32'h50, idAnd, 5'd2, 5'd3, 5'd1, 3'b111, 32'h0);
        putRow("lui", 32'h123452b7, 32'h54, idLui, 5'd8, 5'd3, 5'd5, 3'b001, 32'h12345000);
        putRow("auipc", 32'hfffff317, 32'h58, idAuipc, 5'd31, 5'd31, 5'd6, 3'b001, 32'hfffff000);
        putRow("jalr", 32'h008100e7, 32'h5c, idJalr, 5'd2, 5'd8, 5'd1, 3'b101, 32'h00000008);
        putRow("lb", 32'h00010183, 32'h60, idLb, 5'd2, 5'd0, 5'd3, 3'b101, 32'h00000000);
        putRow("lh", 32'h00211183, 32'h64, idLh, 5'd2, 5'd2, 5'd3, 3'b101, 32'h00000002);
        putRow("lw", 32'hffc12183, 32'h68, idLw, 5'd2, 5'd28, 5'd3, 3'b101, 32'hfffffffc);
        putRow("lbu", 32'h00114183, 32'h6c, idLbu, 5'd2, 5'd1, 5'd3, 3'b101, 32'h00000001);
        putRow("lhu", 32'h00615183, 32'h70, idLhu, 5'd2, 5'd6, 5'd3, 3'b101, 32'h00000006);
        putRow("jal+12", 32'h00c0006f, 32'h74, idJal, 5'd0, 5'd12, 5'd0, 3'b001, 32'h0000000c);
        putRow("sb", 32'h00310023, 32'h80, idSb, 5'd2, 5'd3, 5'd0, 3'b110, 32'h00000000);
        putRow("sh", 32'h00311523, 32'h84, idSh, 5'd2, 5'd3, 5'd10, 3'b110, 32'h0000000a);
        putRow("sw", 32'hfe312c23, 32'h88, idSw, 5'd2, 5'd3, 5'd24, 3'b110, 32'hfffffff8);
        putRow("beq", 32'h00310463, 32'h8c, idBeq, 5'd2, 5'd3, 5'd8, 3'b110, 32'h00000008);
        putRow("bne", 32'hfe311ee3, 32'h90, idBne, 5'd2, 5'd3, 5'd29, 3'b110, 32'hfffffffc);
        putRow("blt", 32'h00314863, 32'h94, idBlt, 5'd2, 5'd3, 5'd16, 3'b110, 32'h00000010);
        putRow("bge", 32'h003150e3, 32'h98, idBge, 5'd2, 5'd3, 5'd1, 3'b110, 32'h00000800);
        putRow("bltu", 32'h02316063, 32'h9c, idBltu, 5'd2, 5'd3, 5'd0, 3'b110, 32'h00000020);
        putRow("bgeu", 32'h00317163, 32'ha0, idBgeu, 5'd2, 5'd3, 5'd2, 3'b110, 32'h00000002);
        putRow("badop", 32'hffffffff, 32'ha4, idIllegal, 5'd31, 5'd31, 5'd31, 3'b000, 32'h0);
        putRow("badload", 32'h00013183, 32'ha8, idIllegal, 5'd2, 5'd0, 5'd3, 3'b000, 32'h0);
        putRow("badstore", 32'h00314023, 32'hac, idIllegal, 5'd2, 5'd3, 5'd0, 3'b000, 32'h0);
        putRow("badbranch", 32'h00312063, 32'hb0, idIllegal, 5'd2, 5'd3, 5'd0, 3'b000, 32'h0);
        putRow("badjalr", 32'h008110e7, 32'hb4, idIllegal, 5'd2, 5'd8, 5'd1, 3'b000, 32'h0);
    endtask

    task automatic fillMemory();
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'hbad0_0000 ^ 32'(i * 4); // low opcode bits 00, never legal
            isProgram[i] = 1'b0;
        end
        for (int r = 0; r < numRows; r++) begin
            mem[rowPc[r][7:2]] = rowWord[r];
            isProgram[rowPc[r][7:2]] = 1'b1;
        end
    endtask

    task automatic checkField(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            errCount++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic compareRow(input int i);
        string tag;
        tag = $sformatf("row %0d %s", i, rowName[i]);
        checkField({tag, " pc"}, rowPc[i], outPc);
        checkField({tag, " opcode"}, 32'(rowWord[i][6:0]), 32'(outOpcode));
        checkField({tag, " instId"}, 32'(rowId[i]), 32'(outInstId));
        checkField({tag, " rs1"}, 32'(rowRs1[i]), 32'(outRs1));
        checkField({tag, " rs2"}, 32'(rowRs2[i]), 32'(outRs2));
        checkField({tag, " rd"}, 32'(rowRd[i]), 32'(outRd));
        checkField({tag, " valid flags"}, 32'(rowVld[i]),
                   32'({outRs1Vld, outRs2Vld, outRdVld}));
        checkField({tag, " imm"}, rowImm[i], outImm);
    endtask

    // answers each request after 1 to 4 cycles
    task automatic serveMemory();
        logic [31:0] r;
        memAck = 1'b0;
        if (ackPending) begin
            if (ackWait == 1) begin
                memAck = 1'b1;
                memData = mem[reqAddr[7:2]];
                ackPending = 1'b0;
            end else
                ackWait--;
        end
        if (memReq) begin
            r = nextRandom();
            if (!sawReq)
                checkField("first fetch address", resetVector, memAddr);
            if (memAddr <= rowPc[numRows-1] && !isProgram[memAddr[7:2]]) begin
                errCount++;
                $display("skipped word at %h was fetched", memAddr);
            end
            reqAddr = memAddr;
            ackWait = 1 + int'(r[17:16]);
            ackPending = 1'b1;
            sawReq = 1'b1;
        end
    endtask

    // stall was just driven, so outValid with stall low is consumed at the next edge
    task automatic checkOutputs();
        if (outValid) begin
            if (!holding)
                compareRow(rowIdx);
            else if (packOutputs() != held) begin
                errCount++;
                $display("row %0d outputs changed while stalled", rowIdx);
            end
            held = packOutputs();
            if (stall)
                holding = 1'b1;
            else begin
                holding = 1'b0;
                rowIdx++;
            end
        end else if (holding) begin
            errCount++;
            $display("row %0d outValid dropped while stalled", rowIdx);
            holding = 1'b0;
        end
    endtask

    initial begin
        logic [31:0] r;
        arstN = 1'b0;
        run = 1'b0;
        memAck = 1'b0;
        memData = '0;
        stall = 1'b0;
        loadProgram();
        if (rowCount != numRows) begin
            errCount++;
            $display("program table holds %0d rows instead of %0d", rowCount, numRows);
        end
        fillMemory();
        repeat (resetCycles) @(negedge clk);
        arstN = 1'b1;
        while (rowIdx < numRows) begin
            @(negedge clk);
            if (!run && (memReq !== 1'b0 || outValid !== 1'b0)) begin
                errCount++;
                $display("activity while run is low at cycle %0d", cycle);
            end
            serveMemory();
            r = nextRandom();
            stall = (r[31:30] == 2'b00);
            checkOutputs();
            if (cycle == idleCycles)
                run = 1'b1;
            cycle++;
        end
        repeat (2) @(negedge clk);
        $display("tbFrontEnd: %0d rows checked, %0d errors", rowIdx, errCount);
        if (errCount == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("timeout after %0d ns with %0d of %0d rows checked", timeoutNs, rowIdx,
                 numRows);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* frontEnd.f */
rvIsaPkg.sv
frontPkg.sv
instructionDecode.sv
fetchControl.sv
programCounter.sv
decodeLatch.sv
frontEnd.sv
tbFrontEnd.sv

/* Makefile */
TOP = tbFrontEnd

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
		-Mdir obj_dir -f frontEnd.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "Simulation PASSED" > /dev/null

clean:
	rm -rf obj_dir
